//--- alu_imm_pipeline.f
+incdir+common
common/core_types_pkg.sv
alu_imm_pipeline/alu_imm_issue_stage.sv
alu_imm_pipeline/alu_imm_operand_stage.sv
alu_imm_pipeline/alu_imm_execute_stage.sv
alu_imm_pipeline/alu_imm_pipeline.sv
tb/alu_imm_pipeline_assert.sv
tb/alu_imm_pipeline_checker.sv
tb/alu_imm_pipeline_tb.sv

//--- alu_imm_pipeline/alu_imm_execute_stage.sv
// ALU immediate execute and writeback stage
// Computes the result of an immediate ALU op from operand A and the
// sign-extended immediate, then registers it with its destination and
// reorder buffer tags. Writeback outputs hold still under back-pressure.

`timescale 1ns/1ps

module alu_imm_execute_stage import core_types_pkg::*; (
  input  logic        CLK,
  input  logic        nRST,

  // From the operand stage
  input  logic        in_valid,
  output logic        in_ready,
  input  alu_imm_op_t in_op,
  input  word_t       in_imm,
  input  word_t       in_A,
  input  phys_reg_t   in_dest_PR,
  input  rob_index_t  in_ROB_index,

  // Writeback
  output logic        WB_valid,
  output word_t       WB_data,
  output phys_reg_t   WB_PR,
  output rob_index_t  WB_ROB_index,
  input  logic        WB_ready
);

  logic       accept;
  logic [4:0] shamt;
  word_t      result;

  assign in_ready = ~WB_valid | WB_ready;
  assign accept   = in_valid & in_ready;

  // Shift amount from the low immediate bits
  assign shamt = in_imm[4:0];

  always_comb begin
    case (in_op)
      ALU_ADDI:  result = in_A + in_imm;
      ALU_SLTI:  result = {31'b0, $signed(in_A) < $signed(in_imm)};
      ALU_SLTIU: result = {31'b0, in_A < in_imm};
      ALU_XORI:  result = in_A ^ in_imm;
      ALU_ORI:   result = in_A | in_imm;
      ALU_ANDI:  result = in_A & in_imm;
      ALU_SLLI:  result = in_A << shamt;
      ALU_SRLI:  result = in_A >> shamt;
      ALU_SRAI:  result = word_t'($signed(in_A) >>> shamt);
      ALU_LOADI: result = in_imm;
      default:   result = '0;
    endcase
  end

  // Writeback valid drops only once the consumer has taken the result
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      WB_valid <= 1'b0;
    end else if (accept) begin
      WB_valid <= 1'b1;
    end else if (WB_ready) begin
      WB_valid <= 1'b0;
    end
  end

  always_ff @(posedge CLK) begin
    if (accept) begin
      WB_data      <= result;
      WB_PR        <= in_dest_PR;
      WB_ROB_index <= in_ROB_index;
    end
  end

endmodule

//--- alu_imm_pipeline/alu_imm_issue_stage.sv
// ALU immediate issue stage
// Captures an issued I-type instruction into the first pipeline register
// and sign-extends its 12-bit immediate to a full word. The instruction
// is held while the operand stage cannot take it.

`timescale 1ns/1ps

module alu_imm_issue_stage import core_types_pkg::*; (
  input  logic        CLK,
  input  logic        nRST,

  // From the issuer
  input  logic        issue_valid,
  input  alu_imm_op_t issue_op,
  input  imm12_t      issue_imm12,
  input  logic        issue_A_forward,
  input  logic        issue_A_is_zero,
  input  bank_t       issue_A_bank,
  input  phys_reg_t   issue_dest_PR,
  input  rob_index_t  issue_ROB_index,
  output logic        issue_ready,

  // To the operand stage
  output logic        out_valid,
  input  logic        out_ready,
  output alu_imm_op_t out_op,
  output word_t       out_imm,
  output logic        out_A_forward,
  output logic        out_A_is_zero,
  output bank_t       out_A_bank,
  output phys_reg_t   out_dest_PR,
  output rob_index_t  out_ROB_index
);

  logic accept;

  // Take a new instruction when empty or when the held one leaves now
  assign issue_ready = ~out_valid | out_ready;
  assign accept      = issue_valid & issue_ready;

  // Stage occupancy
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      out_valid <= 1'b0;
    end else if (accept) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  // Instruction fields, loaded only on a transfer
  always_ff @(posedge CLK) begin
    if (accept) begin
      out_op        <= issue_op;
      out_imm       <= {{20{issue_imm12[11]}}, issue_imm12};
      out_A_forward <= issue_A_forward;
      out_A_is_zero <= issue_A_is_zero;
      out_A_bank    <= issue_A_bank;
      out_dest_PR   <= issue_dest_PR;
      out_ROB_index <= issue_ROB_index;
    end
  end

endmodule

//--- alu_imm_pipeline/alu_imm_operand_stage.sv
// ALU immediate operand stage
// Resolves operand A as hard zero, a forwarded bank value or a register
// file read. A register read must be acknowledged before the instruction
// moves on; read data that arrives while the stage is blocked is kept
// until the instruction is accepted.

`timescale 1ns/1ps

`include "alu_imm_defines.svh"

module alu_imm_operand_stage import core_types_pkg::*; (
  input  logic        CLK,
  input  logic        nRST,

  // From the issue stage
  input  logic        in_valid,
  output logic        in_ready,
  input  alu_imm_op_t in_op,
  input  word_t       in_imm,
  input  logic        in_A_forward,
  input  logic        in_A_is_zero,
  input  bank_t       in_A_bank,
  input  phys_reg_t   in_dest_PR,
  input  rob_index_t  in_ROB_index,

  // Register file read and forwarding network
  input  logic        A_reg_read_ack,
  input  logic        A_reg_read_port,
  input  word_t [`PRF_BANK_COUNT-1:0][`PRF_READ_PORTS-1:0] reg_read_data_by_bank_by_port,
  input  word_t [`PRF_BANK_COUNT-1:0] forward_data_by_bank,

  // To the execute stage
  output logic        out_valid,
  input  logic        out_ready,
  output alu_imm_op_t out_op,
  output word_t       out_imm,
  output word_t       out_A,
  output phys_reg_t   out_dest_PR,
  output rob_index_t  out_ROB_index
);

  logic  needs_read;
  logic  read_held;
  word_t read_hold_data;
  word_t read_data;
  logic  resolved;
  logic  accept;
  word_t operand_a;

  assign needs_read = ~in_A_is_zero & ~in_A_forward;
  assign read_data  = reg_read_data_by_bank_by_port[in_A_bank][A_reg_read_port];

  // Operand known this cycle
  assign resolved = ~needs_read | A_reg_read_ack | read_held;

  assign in_ready = resolved & (~out_valid | out_ready);
  assign accept   = in_valid & in_ready;

  always_comb begin
    if (in_A_is_zero) begin
      operand_a = '0;
    end else if (in_A_forward) begin
      operand_a = forward_data_by_bank[in_A_bank];
    end else if (read_held) begin
      operand_a = read_hold_data;
    end else begin
      operand_a = read_data;
    end
  end

  // Keep the first acknowledged read if the instruction cannot leave yet
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      read_held <= 1'b0;
    end else if (accept) begin
      read_held <= 1'b0;
    end else if (in_valid & needs_read & A_reg_read_ack) begin
      read_held <= 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (in_valid & needs_read & A_reg_read_ack & ~read_held) begin
      read_hold_data <= read_data;
    end
  end

  // Stage occupancy
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      out_valid <= 1'b0;
    end else if (accept) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  always_ff @(posedge CLK) begin
    if (accept) begin
      out_op        <= in_op;
      out_imm       <= in_imm;
      out_A         <= operand_a;
      out_dest_PR   <= in_dest_PR;
      out_ROB_index <= in_ROB_index;
    end
  end

endmodule

//--- alu_imm_pipeline/alu_imm_pipeline.sv
// ALU immediate pipeline
// Execution lane for issued I-type instructions: issue capture, operand
// resolution and execute/writeback, chained by valid/ready links

`timescale 1ns/1ps

`include "alu_imm_defines.svh"

module alu_imm_pipeline import core_types_pkg::*; (
  input  logic        CLK,
  input  logic        nRST,

  // Issue
  input  logic        issue_valid,
  output logic        issue_ready,
  input  alu_imm_op_t issue_op,
  input  imm12_t      issue_imm12,
  input  logic        issue_A_forward,
  input  logic        issue_A_is_zero,
  input  bank_t       issue_A_bank,
  input  phys_reg_t   issue_dest_PR,
  input  rob_index_t  issue_ROB_index,

  // Register read and forwarding
  input  logic        A_reg_read_ack,
  input  logic        A_reg_read_port,
  input  word_t [`PRF_BANK_COUNT-1:0][`PRF_READ_PORTS-1:0] reg_read_data_by_bank_by_port,
  input  word_t [`PRF_BANK_COUNT-1:0] forward_data_by_bank,

  // Writeback
  output logic        WB_valid,
  input  logic        WB_ready,
  output word_t       WB_data,
  output phys_reg_t   WB_PR,
  output rob_index_t  WB_ROB_index
);

  // Issue to operand link
  logic        iss_valid;
  logic        iss_ready;
  alu_imm_op_t iss_op;
  word_t       iss_imm;
  logic        iss_A_forward;
  logic        iss_A_is_zero;
  bank_t       iss_A_bank;
  phys_reg_t   iss_dest_PR;
  rob_index_t  iss_ROB_index;

  // Operand to execute link
  logic        opr_valid;
  logic        opr_ready;
  alu_imm_op_t opr_op;
  word_t       opr_imm;
  word_t       opr_A;
  phys_reg_t   opr_dest_PR;
  rob_index_t  opr_ROB_index;

  alu_imm_issue_stage u_issue (
    .CLK             (CLK),
    .nRST            (nRST),
    .issue_valid     (issue_valid),
    .issue_op        (issue_op),
    .issue_imm12     (issue_imm12),
    .issue_A_forward (issue_A_forward),
    .issue_A_is_zero (issue_A_is_zero),
    .issue_A_bank    (issue_A_bank),
    .issue_dest_PR   (issue_dest_PR),
    .issue_ROB_index (issue_ROB_index),
    .issue_ready     (issue_ready),
    .out_valid       (iss_valid),
    .out_ready       (iss_ready),
    .out_op          (iss_op),
    .out_imm         (iss_imm),
    .out_A_forward   (iss_A_forward),
    .out_A_is_zero   (iss_A_is_zero),
    .out_A_bank      (iss_A_bank),
    .out_dest_PR     (iss_dest_PR),
    .out_ROB_index   (iss_ROB_index)
  );

  alu_imm_operand_stage u_operand (
    .CLK                           (CLK),
    .nRST                          (nRST),
    .in_valid                      (iss_valid),
    .in_ready                      (iss_ready),
    .in_op                         (iss_op),
    .in_imm                        (iss_imm),
    .in_A_forward                  (iss_A_forward),
    .in_A_is_zero                  (iss_A_is_zero),
    .in_A_bank                     (iss_A_bank),
    .in_dest_PR                    (iss_dest_PR),
    .in_ROB_index                  (iss_ROB_index),
    .A_reg_read_ack                (A_reg_read_ack),
    .A_reg_read_port               (A_reg_read_port),
    .reg_read_data_by_bank_by_port (reg_read_data_by_bank_by_port),
    .forward_data_by_bank          (forward_data_by_bank),
    .out_valid                     (opr_valid),
    .out_ready                     (opr_ready),
    .out_op                        (opr_op),
    .out_imm                       (opr_imm),
    .out_A                         (opr_A),
    .out_dest_PR                   (opr_dest_PR),
    .out_ROB_index                 (opr_ROB_index)
  );

  alu_imm_execute_stage u_execute (
    .CLK          (CLK),
    .nRST         (nRST),
    .in_valid     (opr_valid),
    .in_ready     (opr_ready),
    .in_op        (opr_op),
    .in_imm       (opr_imm),
    .in_A         (opr_A),
    .in_dest_PR   (opr_dest_PR),
    .in_ROB_index (opr_ROB_index),
    .WB_valid     (WB_valid),
    .WB_data      (WB_data),
    .WB_PR        (WB_PR),
    .WB_ROB_index (WB_ROB_index),
    .WB_ready     (WB_ready)
  );

endmodule

//--- common/alu_imm_defines.svh
// ALU immediate pipeline sizing
// Physical register file banking, physical register count and reorder
// buffer depth, each with its matching index width

`ifndef ALU_IMM_DEFINES_SVH
`define ALU_IMM_DEFINES_SVH

// Physical register file banks
`define PRF_BANK_COUNT 4
`define LOG_PRF_BANK_COUNT 2

// Physical registers across all banks
`define PR_COUNT 64
`define LOG_PR_COUNT 6

// Reorder buffer depth
`define ROB_ENTRIES 32
`define LOG_ROB_ENTRIES 5

// Read ports per bank
`define PRF_READ_PORTS 2

`endif

//--- common/core_types_pkg.sv
// Core types
// Width typedefs shared by the ALU immediate pipeline and the op encoding
// of the immediate ALU instructions

`include "alu_imm_defines.svh"

package core_types_pkg;

  // Data and immediate widths
  typedef logic [31:0] word_t;
  typedef logic [11:0] imm12_t;

  // Tags carried with an instruction
  typedef logic [`LOG_PRF_BANK_COUNT-1:0] bank_t;
  typedef logic [`LOG_PR_COUNT-1:0]       phys_reg_t;
  typedef logic [`LOG_ROB_ENTRIES-1:0]    rob_index_t;

  // Immediate ALU ops
  typedef enum logic [3:0] {
    ALU_ADDI  = 4'h0,
    ALU_SLTI  = 4'h1,
    ALU_SLTIU = 4'h2,
    ALU_XORI  = 4'h3,
    ALU_ORI   = 4'h4,
    ALU_ANDI  = 4'h5,
    ALU_SLLI  = 4'h6,
    ALU_SRLI  = 4'h7,
    ALU_SRAI  = 4'h8,
    // Sign-extended immediate passes through
    ALU_LOADI = 4'h9
  } alu_imm_op_t;

endpackage

//--- run_sim.sh
#!/bin/sh
# Compile and run the ALU immediate pipeline testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert -j 0 --top-module alu_imm_pipeline_tb \
  -f alu_imm_pipeline.f -o alu_imm_sim > build.log 2>&1 \
  || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/alu_imm_sim > sim.log 2>&1 \
  || echo "Simulator exited with an error status" >> sim.log
cat sim.log
grep -q "SIMULATION FAILED" sim.log && exit 1
grep -q "Simulator exited with an error status" sim.log && exit 1
grep -q "SIMULATION PASSED" sim.log || exit 1
exit 0

//--- tb/alu_imm_pipeline_assert.sv
// ALU immediate pipeline writeback assertions
// Bound into the pipeline top level; checks writeback hold under
// back-pressure and an idle writeback right after reset

`timescale 1ns/1ps

module alu_imm_pipeline_assert import core_types_pkg::*; (
  input logic       CLK,
  input logic       nRST,
  input logic       WB_valid,
  input logic       WB_ready,
  input word_t      WB_data,
  input phys_reg_t  WB_PR,
  input rob_index_t WB_ROB_index
);

  int fail_count = 0;

  // A stalled writeback keeps its data and tags
  wb_stable_a: assert property (@(posedge CLK) disable iff (!nRST)
    WB_valid && !WB_ready |=> WB_valid && $stable(WB_data) && $stable(WB_PR)
      && $stable(WB_ROB_index))
    else begin
      fail_count++;
      $error("writeback outputs changed while stalled");
    end

  reset_idle_a: assert property (@(posedge CLK) $rose(nRST) |-> !WB_valid)
    else begin
      fail_count++;
      $error("WB_valid high in the cycle after reset release");
    end

endmodule

bind alu_imm_pipeline alu_imm_pipeline_assert u_assert (
  .CLK          (CLK),
  .nRST         (nRST),
  .WB_valid     (WB_valid),
  .WB_ready     (WB_ready),
  .WB_data      (WB_data),
  .WB_PR        (WB_PR),
  .WB_ROB_index (WB_ROB_index)
);

//--- tb/alu_imm_pipeline_checker.sv
// ALU immediate pipeline checker
// Models the expected writeback of every accepted issue from the ALU and
// operand source rules, then compares writeback transfers in order

`timescale 1ns/1ps

`include "alu_imm_defines.svh"

module alu_imm_pipeline_checker import core_types_pkg::*; (
  input  logic        CLK,
  input  logic        nRST,
  input  logic        issue_valid,
  input  logic        issue_ready,
  input  alu_imm_op_t issue_op,
  input  imm12_t      issue_imm12,
  input  logic        issue_A_forward,
  input  logic        issue_A_is_zero,
  input  bank_t       issue_A_bank,
  input  phys_reg_t   issue_dest_PR,
  input  rob_index_t  issue_ROB_index,
  input  word_t [`PRF_BANK_COUNT-1:0] bank_reg,
  input  word_t [`PRF_BANK_COUNT-1:0] forward_data_by_bank,
  input  logic        WB_valid,
  input  logic        WB_ready,
  input  word_t       WB_data,
  input  phys_reg_t   WB_PR,
  input  rob_index_t  WB_ROB_index,
  input  logic        test_end,
  output int          pending,
  output int          error_count,
  output int          wb_count
);

  word_t      exp_data[$];
  phys_reg_t  exp_pr[$];
  rob_index_t exp_rob[$];
  int         depth = 0;
  int         errors = 0;
  int         wb_seen = 0;

  assign pending     = depth;
  assign error_count = errors;
  assign wb_count    = wb_seen;

  function automatic word_t model_result(input alu_imm_op_t op, input word_t a,
                                         input imm12_t imm);
    word_t x;
    logic [4:0] sh;
    x = {{20{imm[11]}}, imm};
    sh = imm[4:0];
    case (op)
      ALU_ADDI:  return a + x;
      ALU_SLTI:  return ($signed(a) < $signed(x)) ? 32'd1 : 32'd0;
      ALU_SLTIU: return (a < x) ? 32'd1 : 32'd0;
      ALU_XORI:  return a ^ x;
      ALU_ORI:   return a | x;
      ALU_ANDI:  return a & x;
      ALU_SLLI:  return a << sh;
      ALU_SRLI:  return a >> sh;
      // Vacated top bits refill with the sign
      ALU_SRAI:  return (a >> sh) | (a[31] ? ~(32'hffffffff >> sh) : 32'd0);
      ALU_LOADI: return x;
      default:   return '0;
    endcase
  endfunction

  task automatic compare(input string name, input word_t expected, input word_t actual);
    if (expected !== actual) begin
      $display("** Error: %s expected %h actual %h", name, expected, actual);
      errors++;
    end
  endtask

  // Handshakes are sampled mid-cycle, ahead of the edge that completes them
  always @(negedge CLK) begin
    word_t a;
    if (nRST) begin
      if (WB_valid && WB_ready) begin
        wb_seen++;
        if (exp_data.size() == 0) begin
          $display("Writeback for ROB index %h arrived with nothing outstanding", WB_ROB_index);
          errors++;
        end else begin
          compare("WB_data", exp_data.pop_front(), WB_data);
          compare("WB_PR", word_t'(exp_pr.pop_front()), word_t'(WB_PR));
          compare("WB_ROB_index", word_t'(exp_rob.pop_front()), word_t'(WB_ROB_index));
        end
      end
      if (issue_valid && issue_ready) begin
        if (issue_A_is_zero) begin
          a = '0;
        end else if (issue_A_forward) begin
          a = forward_data_by_bank[issue_A_bank];
        end else begin
          a = bank_reg[issue_A_bank];
        end
        exp_data.push_back(model_result(issue_op, a, issue_imm12));
        exp_pr.push_back(issue_dest_PR);
        exp_rob.push_back(issue_ROB_index);
      end
      if (test_end && exp_data.size() != 0) begin
        $display("%0d expected writebacks never arrived", exp_data.size());
        errors++;
        exp_data.delete();
        exp_pr.delete();
        exp_rob.delete();
      end
      depth = exp_data.size();
    end
  end

endmodule

//--- tb/alu_imm_pipeline_tb.sv
// ALU immediate pipeline testbench
// Drives random I-type instructions into the pipeline and plays the
// register file, the forwarding network and the writeback consumer

`timescale 1ns/1ps

`include "alu_imm_defines.svh"

module alu_imm_pipeline_tb import core_types_pkg::*; ();

  localparam int CLK_PERIOD = 4;
  localparam int N_OPS = 200;
  localparam int N_SRC = 200;
  localparam int N_WAIT = 150;
  localparam int N_BP = 200;
  localparam int N_TPUT = 100;
  localparam int WATCHDOG_CYCLES = (N_OPS + N_SRC + N_WAIT + N_BP + N_TPUT) * 20 + 1000;

  logic        CLK;
  logic        nRST;
  logic        issue_valid;
  logic        issue_ready;
  alu_imm_op_t issue_op;
  imm12_t      issue_imm12;
  logic        issue_A_forward;
  logic        issue_A_is_zero;
  bank_t       issue_A_bank;
  phys_reg_t   issue_dest_PR;
  rob_index_t  issue_ROB_index;
  logic        A_reg_read_ack;
  logic        A_reg_read_port;
  word_t [`PRF_BANK_COUNT-1:0][`PRF_READ_PORTS-1:0] reg_read_data_by_bank_by_port;
  word_t [`PRF_BANK_COUNT-1:0] forward_data_by_bank;
  word_t [`PRF_BANK_COUNT-1:0] bank_reg;
  logic        WB_valid;
  logic        WB_ready;
  word_t       WB_data;
  phys_reg_t   WB_PR;
  rob_index_t  WB_ROB_index;
  logic        test_end;
  int          pending;
  int          error_count;
  int          wb_count;
  int          cycle = 0;
  int          tb_errors = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  logic [31:0] lfsr_state = 32'hf134;

  always #(CLK_PERIOD / 2) CLK = ~CLK;

  always @(posedge CLK) cycle <= cycle + 1;

  // Both read ports of a bank return that bank's register value
  for (genvar b = 0; b < `PRF_BANK_COUNT; b++) begin : g_bank
    assign reg_read_data_by_bank_by_port[b] = {`PRF_READ_PORTS{bank_reg[b]}};
  end

  alu_imm_pipeline u_dut (.*);

  alu_imm_pipeline_checker u_checker (.*);

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  function automatic logic rand_bit();
    lfsr_state = lfsr_next(lfsr_state);
    return lfsr_state[0];
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) v = {v[30:0], rand_bit()};
    return v;
  endfunction

  function automatic int total_errors();
    return error_count + tb_errors + u_dut.u_assert.fail_count;
  endfunction

  task automatic load_banks();
    bank_t bi;
    bi = '0;
    repeat (`PRF_BANK_COUNT) begin
      bank_reg[bi] = rand_bits(32);
      forward_data_by_bank[bi] = rand_bits(32);
      bi = bi + 1'b1;
    end
  endtask

  // Source pick 0 is hard zero, 1 is forwarded, the rest read registers
  task automatic drive_issue(input logic mixed_src);
    logic [1:0] src;
    src = mixed_src ? 2'(rand_bits(2)) : 2'd3;
    issue_valid = 1'b1;
    issue_op = alu_imm_op_t'(4'(rand_bits(4) % 32'd10));
    issue_imm12 = imm12_t'(rand_bits(12));
    issue_A_is_zero = (src == 2'd0);
    issue_A_forward = (src == 2'd1);
    issue_A_bank = bank_t'(rand_bits(`LOG_PRF_BANK_COUNT));
    issue_dest_PR = phys_reg_t'(rand_bits(`LOG_PR_COUNT));
    issue_ROB_index = issue_ROB_index + 1'b1;
  endtask

  task automatic finish_test(input string name, input int errs_before);
    int errs;
    errs = total_errors() - errs_before;
    tests_run++;
    if (errs != 0) tests_failed++;
    $display("Test %s: %s, %0d errors", name, (errs == 0) ? "ok" : "failed", errs);
  endtask

  task automatic run_test(input string name, input int n_issue, input logic mixed_src,
                          input logic slow_ack, input logic slow_wb, input logic sparse,
                          input logic check_tput);
    int issued;
    int hold;
    int errs_before;
    int wb_before;
    int first_issue;
    int first_wb;
    int waited;
    logic took;
    errs_before = total_errors();
    wb_before = wb_count;
    issued = 0;
    hold = 0;
    first_issue = -1;
    first_wb = -1;
    load_banks();
    while (issued < n_issue) begin
      @(negedge CLK);
      took = issue_valid & issue_ready;
      if (took) begin
        issued++;
        if (first_issue < 0) first_issue = cycle;
      end
      if (WB_valid && first_wb < 0) first_wb = cycle;
      @(posedge CLK);
      #1;
      if (took || !issue_valid) begin
        issue_valid = 1'b0;
        if (issued < n_issue && (!sparse || rand_bit())) drive_issue(mixed_src);
      end
      // Withheld acknowledge runs of one to four cycles
      if (hold > 0) begin
        A_reg_read_ack = 1'b0;
        hold--;
      end else begin
        A_reg_read_ack = 1'b1;
        if (slow_ack && rand_bit()) hold = int'(rand_bits(2)) + 1;
      end
      A_reg_read_port = rand_bit();
      WB_ready = slow_wb ? rand_bit() : 1'b1;
    end
    A_reg_read_ack = 1'b1;
    WB_ready = 1'b1;
    waited = 0;
    while ((pending != 0 || WB_valid) && waited < 50) begin
      @(posedge CLK);
      #1;
      waited++;
    end
    test_end = 1'b1;
    @(posedge CLK);
    #1;
    test_end = 1'b0;
    if (check_tput) begin
      if (wb_count - wb_before != issued) begin
        $display("** Error: WB_valid transfers expected %h actual %h",
                 issued, wb_count - wb_before);
        tb_errors++;
      end
      // Handshake cycle to first writeback cycle
      if (first_wb - first_issue != 3) begin
        $display("** Error: WB_valid latency expected %h actual %h", 3, first_wb - first_issue);
        tb_errors++;
      end
    end
    finish_test(name, errs_before);
  endtask

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin
    CLK = 1'b0;
    nRST = 1'b0;
    issue_valid = 1'b0;
    issue_op = ALU_ADDI;
    issue_imm12 = '0;
    issue_A_forward = 1'b0;
    issue_A_is_zero = 1'b0;
    issue_A_bank = '0;
    issue_dest_PR = '0;
    issue_ROB_index = '0;
    A_reg_read_ack = 1'b1;
    A_reg_read_port = 1'b0;
    WB_ready = 1'b1;
    bank_reg = '0;
    forward_data_by_bank = '0;
    test_end = 1'b0;
    repeat (3) @(posedge CLK);
    #1;
    nRST = 1'b1;
    @(negedge CLK);
    if (WB_valid !== 1'b0) begin
      $display("** Error: WB_valid expected %h actual %h", 1'b0, WB_valid);
      tb_errors++;
    end
    if (issue_ready !== 1'b1) begin
      $display("** Error: issue_ready expected %h actual %h", 1'b1, issue_ready);
      tb_errors++;
    end
    finish_test("reset", 0);
    @(posedge CLK);
    #1;
    run_test("alu_ops", N_OPS, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    run_test("operand_src", N_SRC, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
    run_test("read_wait", N_WAIT, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
    run_test("backpressure", N_BP, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0);
    run_test("throughput", N_TPUT, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
    $display("Tests %0d, failed %0d, errors %0d, writebacks %0d",
             tests_run, tests_failed, total_errors(), wb_count);
    if (total_errors() == 0 && tests_failed == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule
